// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_ctrl_block -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    exit 1
fi
exit 0

// ==== source/ctrl_block.sv ====
`timescale 1ns/1ns

module ctrl_block #(
    parameter int IBUF_DEPTH = 8,
    parameter int ROB_DEPTH  = 16
) (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_fetch_vld,
    input  ctrl_pkg::fetch_entry_t i_fetch,
    output logic                   o_stall,
    input  logic                   i_int_stall,
    output logic                   o_disp_vld,
    output ctrl_pkg::disp_info_t   o_disp_info,
    input  logic                   i_wb_vld,
    input  ctrl_pkg::wb_info_t     i_wb,
    output logic                   o_commit_vld,
    output ctrl_pkg::commit_info_t o_commit,
    output logic                   o_squash_vld,
    output ctrl_pkg::squash_info_t o_squash
);
    logic                   buf_vld;
    ctrl_pkg::fetch_entry_t buf_data;
    logic                   dec_rdy;
    logic                   dec_vld;
    ctrl_pkg::dec_info_t    dec_info;
    logic                   ren_rdy;
    logic                   ren_vld;
    ctrl_pkg::rename_info_t ren_info;
    logic                   disp_stall;
    logic                   alloc_vld;
    ctrl_pkg::rob_entry_t   alloc_entry;
    logic                   can_alloc;
    ctrl_pkg::rob_idx_t     alloc_idx;

    // fetch is accepted only while the buffer has room
    inst_buffer #(.IBUF_DEPTH(IBUF_DEPTH)) u_inst_buffer (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_flush   (o_squash_vld),
        .i_enq_vld (i_fetch_vld && !o_stall),
        .i_enq     (i_fetch),
        .o_full    (o_stall),
        .o_deq_vld (buf_vld),
        .o_deq     (buf_data),
        .i_deq_rdy (dec_rdy)
    );

    decode u_decode (
        .clk     (clk),
        .i_rst   (i_rst),
        .i_flush (o_squash_vld),
        .i_vld   (buf_vld),
        .i_fetch (buf_data),
        .o_rdy   (dec_rdy),
        .i_stall (!ren_rdy),
        .o_vld   (dec_vld),
        .o_info  (dec_info)
    );

    rename u_rename (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_flush      (o_squash_vld),
        .i_vld        (dec_vld),
        .i_info       (dec_info),
        .o_rdy        (ren_rdy),
        .i_stall      (disp_stall),
        .o_vld        (ren_vld),
        .o_info       (ren_info),
        .i_commit_vld (o_commit_vld),
        .i_commit     (o_commit)
    );

    dispatch u_dispatch (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_flush       (o_squash_vld),
        .i_vld         (ren_vld),
        .i_info        (ren_info),
        .o_stall       (disp_stall),
        .o_alloc_vld   (alloc_vld),
        .o_alloc_entry (alloc_entry),
        .i_can_alloc   (can_alloc),
        .i_alloc_idx   (alloc_idx),
        .i_int_stall   (i_int_stall),
        .o_disp_vld    (o_disp_vld),
        .o_disp_info   (o_disp_info)
    );

    rob #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_alloc_vld   (alloc_vld),
        .i_alloc_entry (alloc_entry),
        .o_can_alloc   (can_alloc),
        .o_alloc_idx   (alloc_idx),
        .i_wb_vld      (i_wb_vld),
        .i_wb          (i_wb),
        .o_commit_vld  (o_commit_vld),
        .o_commit      (o_commit),
        .o_squash_vld  (o_squash_vld),
        .o_squash      (o_squash)
    );

endmodule

// ==== source/ctrl_pkg.sv ====
package ctrl_pkg;

    localparam int NUM_AREG = 32;
    localparam int NUM_PREG = 64;

    typedef logic [$clog2(NUM_AREG)-1:0] areg_idx_t;
    typedef logic [$clog2(NUM_PREG)-1:0] preg_idx_t;
    // wide enough for the largest ROB
    typedef logic [3:0] rob_idx_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_entry_t;

    typedef struct packed {
        logic [31:0] pc;
        areg_idx_t   rs1;
        areg_idx_t   rs2;
        areg_idx_t   rd;
        logic        rs2_used;
        logic        rd_wr;
        logic        illegal;
        logic [11:0] imm;
    } dec_info_t;

    typedef struct packed {
        dec_info_t dec;
        preg_idx_t prs1;
        preg_idx_t prs2;
        preg_idx_t prd;
        preg_idx_t old_prd;
    } rename_info_t;

    typedef struct packed {
        rename_info_t ren;
        rob_idx_t     rob_idx;
    } disp_info_t;

    typedef struct packed {
        logic [31:0] pc;
        areg_idx_t   rd;
        preg_idx_t   prd;
        preg_idx_t   old_prd;
        logic        rd_wr;
        logic        illegal;
        logic        complete;
    } rob_entry_t;

    typedef struct packed {
        rob_idx_t rob_idx;
    } wb_info_t;

    typedef struct packed {
        rob_idx_t  rob_idx;
        areg_idx_t rd;
        preg_idx_t prd;
        preg_idx_t old_prd;
        logic      rd_wr;
    } commit_info_t;

    typedef struct packed {
        logic [31:0] pc;
    } squash_info_t;

endpackage

// ==== source/decode.sv ====
`timescale 1ns/1ns

module decode (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_flush,
    input  logic                   i_vld,
    input  ctrl_pkg::fetch_entry_t i_fetch,
    output logic                   o_rdy,
    input  logic                   i_stall,
    output logic                   o_vld,
    output ctrl_pkg::dec_info_t    o_info
);
    isa_pkg::inst_word_t word;
    ctrl_pkg::dec_info_t dec_next;
    logic                is_op;
    logic                is_op_imm;
    logic                illegal;

    assign word      = i_fetch.inst;
    assign is_op     = word.r.opcode == isa_pkg::OPC_OP;
    assign is_op_imm = word.i.opcode == isa_pkg::OPC_OP_IMM;
    assign illegal   = !(is_op || is_op_imm);

    // register takes a new word when empty or when rename drains it
    assign o_rdy = !o_vld || !i_stall;

    always_comb begin
        dec_next.pc  = i_fetch.pc;
        dec_next.rs1 = word.r.rs1;
        dec_next.rs2 = word.r.rs2;
        dec_next.rd  = word.r.rd;
        // only R-type reads a second source
        dec_next.rs2_used = is_op;
        dec_next.rd_wr    = !illegal && (word.r.rd != '0);
        dec_next.illegal  = illegal;
        dec_next.imm      = is_op_imm ? word.i.imm12 : 12'h000;
    end

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            o_vld <= 1'b0;
        end else if (o_rdy) begin
            o_vld <= i_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (o_rdy && i_vld) begin
            o_info <= dec_next;
        end
    end

endmodule

// ==== source/dispatch.sv ====
`timescale 1ns/1ns

module dispatch (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_flush,
    input  logic                   i_vld,
    input  ctrl_pkg::rename_info_t i_info,
    output logic                   o_stall,
    output logic                   o_alloc_vld,
    output ctrl_pkg::rob_entry_t   o_alloc_entry,
    input  logic                   i_can_alloc,
    input  ctrl_pkg::rob_idx_t     i_alloc_idx,
    input  logic                   i_int_stall,
    output logic                   o_disp_vld,
    output ctrl_pkg::disp_info_t   o_disp_info
);
    logic out_free;
    logic take;

    // output slot is empty or being drained by the issue side
    assign out_free = !o_disp_vld || !i_int_stall;
    assign o_stall  = !(out_free && i_can_alloc);
    assign take     = i_vld && !o_stall;

    assign o_alloc_vld            = take;
    assign o_alloc_entry.pc       = i_info.dec.pc;
    assign o_alloc_entry.rd       = i_info.dec.rd;
    assign o_alloc_entry.prd      = i_info.prd;
    assign o_alloc_entry.old_prd  = i_info.old_prd;
    assign o_alloc_entry.rd_wr    = i_info.dec.rd_wr;
    assign o_alloc_entry.illegal  = i_info.dec.illegal;
    // illegal entries never see a writeback
    assign o_alloc_entry.complete = i_info.dec.illegal;

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            o_disp_vld <= 1'b0;
        end else if (out_free) begin
            o_disp_vld <= take && !i_info.dec.illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            o_disp_info <= '{ren: i_info, rob_idx: i_alloc_idx};
        end
    end

endmodule

// ==== source/inst_buffer.sv ====
`timescale 1ns/1ns

module inst_buffer #(
    parameter int IBUF_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_flush,
    input  logic                   i_enq_vld,
    input  ctrl_pkg::fetch_entry_t i_enq,
    output logic                   o_full,
    output logic                   o_deq_vld,
    output ctrl_pkg::fetch_entry_t o_deq,
    input  logic                   i_deq_rdy
);
    localparam int PTR_W = (IBUF_DEPTH > 1) ? $clog2(IBUF_DEPTH) : 1;

    ctrl_pkg::fetch_entry_t mem [IBUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             enq;
    logic             deq;

    assign o_full    = count == (PTR_W + 1)'(IBUF_DEPTH);
    assign o_deq_vld = count != '0;
    assign o_deq     = mem[rd_ptr];

    assign enq = i_enq_vld;
    assign deq = o_deq_vld && i_deq_rdy;

    // pointers wrap explicitly so any depth works
    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq) begin
                wr_ptr <= (wr_ptr == PTR_W'(IBUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (deq) begin
                rd_ptr <= (rd_ptr == PTR_W'(IBUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + {{PTR_W{1'b0}}, enq} - {{PTR_W{1'b0}}, deq};
        end
    end

    always_ff @(posedge clk) begin
        if (enq) begin
            mem[wr_ptr] <= i_enq;
        end
    end

    // the top level gates fetch with o_stall
    enq_not_full: assert property (@(posedge clk) disable iff (i_rst) i_enq_vld |-> !o_full);

endmodule

// ==== source/isa_pkg.sv ====
package isa_pkg;

    // major opcodes of the two supported classes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // register-register format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    // register-immediate format
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // one fetched word, viewed in either format
    // opcode, rd, funct3 and rs1 sit at the same bits in both
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } inst_word_t;

endpackage

// ==== source/rename.sv ====
`timescale 1ns/1ns

module rename (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_flush,
    input  logic                   i_vld,
    input  ctrl_pkg::dec_info_t    i_info,
    output logic                   o_rdy,
    input  logic                   i_stall,
    output logic                   o_vld,
    output ctrl_pkg::rename_info_t o_info,
    input  logic                   i_commit_vld,
    input  ctrl_pkg::commit_info_t i_commit
);
    localparam int NUM_FREE = ctrl_pkg::NUM_PREG - ctrl_pkg::NUM_AREG;
    localparam int FL_W     = $clog2(NUM_FREE);

    ctrl_pkg::preg_idx_t spec_rat [ctrl_pkg::NUM_AREG];
    ctrl_pkg::preg_idx_t comm_rat [ctrl_pkg::NUM_AREG];
    ctrl_pkg::preg_idx_t free_list [NUM_FREE];
    // one extra bit tells full from empty
    logic [FL_W:0]          fl_head;
    logic [FL_W:0]          fl_tail;
    logic [FL_W:0]          fl_comm_head;
    logic                   fl_empty;
    logic                   fl_full;
    logic                   fire;
    logic                   pop;
    logic                   push;
    ctrl_pkg::rename_info_t ren_next;

    assign fl_empty = fl_head == fl_tail;
    assign fl_full  = (fl_head[FL_W] != fl_tail[FL_W]) &&
                      (fl_head[FL_W-1:0] == fl_tail[FL_W-1:0]);

    assign o_rdy = !o_vld || !i_stall;
    assign fire  = i_vld && o_rdy;
    assign pop   = fire && i_info.rd_wr;
    assign push  = i_commit_vld && i_commit.rd_wr;

    always_comb begin
        ren_next.dec     = i_info;
        ren_next.prs1    = spec_rat[i_info.rs1];
        ren_next.prs2    = spec_rat[i_info.rs2];
        ren_next.prd     = i_info.rd_wr ? free_list[fl_head[FL_W-1:0]] : '0;
        ren_next.old_prd = spec_rat[i_info.rd];
    end

    // map tables and free list; the lists start as identity and p32..p63
    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < ctrl_pkg::NUM_AREG; i++) begin
                spec_rat[i] <= ctrl_pkg::preg_idx_t'(i);
                comm_rat[i] <= ctrl_pkg::preg_idx_t'(i);
            end
            for (int i = 0; i < NUM_FREE; i++) begin
                free_list[i] <= ctrl_pkg::preg_idx_t'(ctrl_pkg::NUM_AREG + i);
            end
            fl_head      <= '0;
            fl_tail      <= {1'b1, {FL_W{1'b0}}};
            fl_comm_head <= '0;
        end else begin
            // retired writer frees the register it replaced
            if (push) begin
                comm_rat[i_commit.rd]            <= i_commit.prd;
                free_list[fl_tail[FL_W-1:0]]     <= i_commit.old_prd;
                fl_tail                          <= fl_tail + 1'b1;
                fl_comm_head                     <= fl_comm_head + 1'b1;
            end
            if (i_flush) begin
                spec_rat <= comm_rat;
                fl_head  <= fl_comm_head;
            end else if (pop) begin
                spec_rat[i_info.rd] <= ren_next.prd;
                fl_head             <= fl_head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            o_vld <= 1'b0;
        end else if (o_rdy) begin
            o_vld <= i_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            o_info <= ren_next;
        end
    end

    // ROB depth bounds in-flight writers below the free-list size
    fl_no_underflow: assert property (@(posedge clk) disable iff (i_rst)
        pop && !i_flush |-> !fl_empty);
    fl_no_overflow: assert property (@(posedge clk) disable iff (i_rst)
        push |-> !fl_full);

endmodule

// ==== source/rob.sv ====
`timescale 1ns/1ns

module rob #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_alloc_vld,
    input  ctrl_pkg::rob_entry_t   i_alloc_entry,
    output logic                   o_can_alloc,
    output ctrl_pkg::rob_idx_t     o_alloc_idx,
    input  logic                   i_wb_vld,
    input  ctrl_pkg::wb_info_t     i_wb,
    output logic                   o_commit_vld,
    output ctrl_pkg::commit_info_t o_commit,
    output logic                   o_squash_vld,
    output ctrl_pkg::squash_info_t o_squash
);
    localparam int IDX_W = $clog2(ROB_DEPTH);

    ctrl_pkg::rob_entry_t entries [ROB_DEPTH];
    logic [IDX_W-1:0]     head;
    logic [IDX_W-1:0]     tail;
    logic [IDX_W:0]       count;
    logic [IDX_W-1:0]     wb_idx;
    logic [IDX_W-1:0]     wb_off;
    ctrl_pkg::rob_entry_t head_entry;
    logic                 head_done;
    logic                 do_commit;
    logic                 do_squash;

    assign head_entry = entries[head];
    // nothing retires while a squash is in flight
    assign head_done  = (count != '0) && head_entry.complete && !o_squash_vld;
    assign do_commit  = head_done && !head_entry.illegal;
    assign do_squash  = head_done && head_entry.illegal;

    // depth is a power of two, so the top count bit means full
    assign o_can_alloc = !count[IDX_W];
    assign o_alloc_idx = ctrl_pkg::rob_idx_t'(tail);

    assign wb_idx = i_wb.rob_idx[IDX_W-1:0];
    assign wb_off = wb_idx - head;

    always_ff @(posedge clk) begin
        if (i_rst || o_squash_vld) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (i_alloc_vld) begin
                tail <= tail + 1'b1;
            end
            if (do_commit) begin
                head <= head + 1'b1;
            end
            count <= count + {{IDX_W{1'b0}}, i_alloc_vld} - {{IDX_W{1'b0}}, do_commit};
        end
    end

    // alloc hits the free tail slot, writebacks only occupied ones
    always_ff @(posedge clk) begin
        if (i_alloc_vld) begin
            entries[tail] <= i_alloc_entry;
        end
        if (i_wb_vld) begin
            entries[wb_idx].complete <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_commit_vld <= 1'b0;
            o_squash_vld <= 1'b0;
        end else begin
            o_commit_vld <= do_commit;
            o_squash_vld <= do_squash;
        end
    end

    always_ff @(posedge clk) begin
        if (do_commit) begin
            o_commit.rob_idx <= ctrl_pkg::rob_idx_t'(head);
            o_commit.rd      <= head_entry.rd;
            o_commit.prd     <= head_entry.prd;
            o_commit.old_prd <= head_entry.old_prd;
            o_commit.rd_wr   <= head_entry.rd_wr;
        end
        if (do_squash) begin
            o_squash.pc <= head_entry.pc;
        end
    end

    // execution side may only complete dispatched, uncommitted work
    wb_occupied: assert property (@(posedge clk) disable iff (i_rst)
        i_wb_vld |-> ({1'b0, wb_off} < count));

endmodule

// ==== tb.f ====
source/isa_pkg.sv
source/ctrl_pkg.sv
source/inst_buffer.sv
source/decode.sv
source/rename.sv
source/dispatch.sv
source/rob.sv
source/ctrl_block.sv
testbench/tb_clock.sv
testbench/tb_ctrl_block.sv

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

// ==== testbench/tb_ctrl_block.sv ====
`timescale 1ns/1ns

module tb_ctrl_block;
    localparam int IBUF_DEPTH = 8;
    localparam int ROB_DEPTH  = 16;
    localparam int PERIOD     = 40;
    // cycle budget per test
    localparam int T_RESET  = 20;
    localparam int T_RENAME = 60;
    localparam int T_COMMIT = 120;
    localparam int T_BP     = 300;
    localparam int T_ILL    = 250;
    localparam int T_FULL   = 400;
    localparam int T_MARGIN = 200;
    localparam int TIMEOUT_NS =
        (T_RESET + T_RENAME + T_COMMIT + T_BP + T_ILL + T_FULL + T_MARGIN) * PERIOD;

    // one expected retirement or squash
    typedef struct packed {
        logic                   illegal;
        logic [31:0]            pc;
        ctrl_pkg::commit_info_t c;
    } exp_retire_t;

    logic                   clk;
    logic                   i_rst;
    logic                   i_fetch_vld;
    ctrl_pkg::fetch_entry_t i_fetch;
    logic                   o_stall;
    logic                   i_int_stall;
    logic                   o_disp_vld;
    ctrl_pkg::disp_info_t   o_disp_info;
    logic                   i_wb_vld;
    ctrl_pkg::wb_info_t     i_wb;
    logic                   o_commit_vld;
    ctrl_pkg::commit_info_t o_commit;
    logic                   o_squash_vld;
    ctrl_pkg::squash_info_t o_squash;

    // reference model state
    ctrl_pkg::preg_idx_t    spec_rat [32];
    ctrl_pkg::preg_idx_t    comm_rat [32];
    ctrl_pkg::preg_idx_t    free_q [32];
    int                     fl_head;
    int                     fl_tail;
    int                     fl_comm;
    ctrl_pkg::rob_idx_t     next_rob;
    ctrl_pkg::fetch_entry_t prog_q [$];
    exp_retire_t            retire_q [$];
    ctrl_pkg::rob_idx_t     pending [$];
    logic                   held_vld;
    ctrl_pkg::disp_info_t   held_info;

    int          seed = 69851;
    int          errors = 0;
    int          checks = 0;
    int          disp_cnt = 0;
    int          commit_cnt = 0;
    int          squash_cnt = 0;
    logic [31:0] next_pc = 32'h0000_1000;

    tb_clock #(.PERIOD(PERIOD)) u_clock (.clk(clk));

    ctrl_block #(.IBUF_DEPTH(IBUF_DEPTH), .ROB_DEPTH(ROB_DEPTH)) i_ctrl_block (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_fetch_vld  (i_fetch_vld),
        .i_fetch      (i_fetch),
        .o_stall      (o_stall),
        .i_int_stall  (i_int_stall),
        .o_disp_vld   (o_disp_vld),
        .o_disp_info  (o_disp_info),
        .i_wb_vld     (i_wb_vld),
        .i_wb         (i_wb),
        .o_commit_vld (o_commit_vld),
        .o_commit     (o_commit),
        .o_squash_vld (o_squash_vld),
        .o_squash     (o_squash)
    );

    function automatic logic [31:0] mk_r(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        isa_pkg::inst_word_t w;
        w.r.funct7 = 7'd0;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = 3'd0;
        w.r.rd     = rd;
        w.r.opcode = isa_pkg::OPC_OP;
        return w;
    endfunction

    function automatic logic [31:0] mk_i(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        isa_pkg::inst_word_t w;
        w.i.imm12  = imm;
        w.i.rs1    = rs1;
        w.i.funct3 = 3'd0;
        w.i.rd     = rd;
        w.i.opcode = isa_pkg::OPC_OP_IMM;
        return w;
    endfunction

    task automatic fail_msg(string what);
        errors++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic expect_low(string name, logic got);
        checks++;
        if (got !== 1'b0) begin
            errors++;
            $display("FAIL %0t %s exp=0 got=%b", $time, name, got);
        end
    endtask

    // illegal words take a ROB slot but never reach the issue side
    task automatic advance_illegals();
        isa_pkg::inst_word_t w;
        exp_retire_t         e;
        while (prog_q.size() > 0) begin
            w = prog_q[0].inst;
            if (w.r.opcode == isa_pkg::OPC_OP || w.r.opcode == isa_pkg::OPC_OP_IMM) begin
                break;
            end
            e = '0;
            e.illegal = 1'b1;
            e.pc = prog_q[0].pc;
            retire_q.push_back(e);
            void'(prog_q.pop_front());
            next_rob = ctrl_pkg::rob_idx_t'((int'(next_rob) + 1) % ROB_DEPTH);
        end
    endtask

    task automatic check_dispatch();
        ctrl_pkg::fetch_entry_t f;
        isa_pkg::inst_word_t    w;
        ctrl_pkg::disp_info_t   e;
        exp_retire_t            r;
        advance_illegals();
        if (prog_q.size() == 0) begin
            fail_msg("dispatch seen with no instruction in flight");
            return;
        end
        f = prog_q.pop_front();
        w = f.inst;
        e = '0;
        e.ren.dec.pc       = f.pc;
        e.ren.dec.rs1      = w.r.rs1;
        e.ren.dec.rs2      = w.r.rs2;
        e.ren.dec.rd       = w.r.rd;
        e.ren.dec.rs2_used = w.r.opcode == isa_pkg::OPC_OP;
        e.ren.dec.rd_wr    = w.r.rd != 5'd0;
        e.ren.dec.imm      = (w.r.opcode == isa_pkg::OPC_OP_IMM) ? w.i.imm12 : 12'h000;
        e.ren.prs1         = spec_rat[w.r.rs1];
        e.ren.prs2         = spec_rat[w.r.rs2];
        e.ren.old_prd      = spec_rat[w.r.rd];
        e.ren.prd          = e.ren.dec.rd_wr ? free_q[fl_head % 32] : '0;
        e.rob_idx          = next_rob;
        checks++;
        if (o_disp_info != e) begin
            errors++;
            $display("FAIL %0t o_disp_info exp=%h got=%h", $time, e, o_disp_info);
        end
        if (e.ren.dec.rd_wr) begin
            spec_rat[w.r.rd] = e.ren.prd;
            fl_head++;
        end
        r = '0;
        r.pc        = f.pc;
        r.c.rob_idx = next_rob;
        r.c.rd      = w.r.rd;
        r.c.prd     = e.ren.prd;
        r.c.old_prd = e.ren.old_prd;
        r.c.rd_wr   = e.ren.dec.rd_wr;
        retire_q.push_back(r);
        pending.push_back(next_rob);
        next_rob = ctrl_pkg::rob_idx_t'((int'(next_rob) + 1) % ROB_DEPTH);
        disp_cnt++;
    endtask

    task automatic check_commit();
        exp_retire_t r;
        if (retire_q.size() == 0 || retire_q[0].illegal) begin
            fail_msg("commit seen where none was expected");
            return;
        end
        r = retire_q.pop_front();
        checks++;
        if (o_commit != r.c) begin
            errors++;
            $display("FAIL %0t o_commit exp=%h got=%h", $time, r.c, o_commit);
        end
        if (r.c.rd_wr) begin
            comm_rat[r.c.rd] = r.c.prd;
            free_q[fl_tail % 32] = r.c.old_prd;
            fl_tail++;
            fl_comm++;
        end
        commit_cnt++;
    endtask

    task automatic check_squash();
        advance_illegals();
        checks++;
        if (retire_q.size() == 0 || !retire_q[0].illegal) begin
            fail_msg("squash seen while the oldest instruction is legal");
        end else if (o_squash.pc != retire_q[0].pc) begin
            errors++;
            $display("FAIL %0t o_squash.pc exp=%h got=%h", $time, retire_q[0].pc, o_squash.pc);
        end
        retire_q.delete();
        prog_q.delete();
        pending.delete();
        spec_rat = comm_rat;
        fl_head = fl_comm;
        next_rob = '0;
        squash_cnt++;
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!i_rst) begin
            if (held_vld) begin
                checks++;
                if (!o_disp_vld) begin
                    errors++;
                    $display("FAIL %0t o_disp_vld exp=1 got=%b", $time, o_disp_vld);
                end else if (o_disp_info != held_info) begin
                    errors++;
                    $display("FAIL %0t o_disp_info exp=%h got=%h", $time, held_info, o_disp_info);
                end
            end
            held_vld = o_disp_vld && i_int_stall;
            held_info = o_disp_info;
            if (o_disp_vld && !i_int_stall) begin
                check_dispatch();
            end
            if (o_commit_vld) begin
                check_commit();
            end
            if (o_squash_vld) begin
                check_squash();
            end
        end
    end

    task automatic tick();
        @(posedge clk);
        #5;
    endtask

    task automatic fetch(logic [31:0] inst);
        logic taken;
        i_fetch_vld = 1'b1;
        i_fetch.pc = next_pc;
        i_fetch.inst = inst;
        taken = 1'b0;
        while (!taken) begin
            taken = !o_stall;
            tick();
        end
        prog_q.push_back(i_fetch);
        i_fetch_vld = 1'b0;
        next_pc = next_pc + 32'd4;
    endtask

    task automatic writeback(int k);
        i_wb_vld = 1'b1;
        i_wb.rob_idx = pending[k];
        pending.delete(k);
        tick();
        i_wb_vld = 1'b0;
    endtask

    // completes pending work in random order until both counts are met
    task automatic run_until(int disp_target, int commit_target, int limit);
        int n;
        n = 0;
        while ((disp_cnt < disp_target || commit_cnt < commit_target) && n < limit) begin
            if (pending.size() > 0) begin
                writeback(int'($unsigned($random(seed)) % pending.size()));
            end else begin
                tick();
            end
            n++;
        end
        if (n >= limit) begin
            fail_msg("timed out waiting for dispatches or commits");
        end
    endtask

    task automatic wait_disp(int target, int limit);
        int n;
        n = 0;
        while (disp_cnt < target && n < limit) begin
            tick();
            n++;
        end
        if (n >= limit) begin
            fail_msg("timed out waiting for dispatches");
        end
    endtask

    task automatic test_reset();
        expect_low("o_disp_vld", o_disp_vld);
        expect_low("o_commit_vld", o_commit_vld);
        expect_low("o_squash_vld", o_squash_vld);
        expect_low("o_stall", o_stall);
    endtask

    task automatic test_rename();
        fetch(mk_i(5'd1, 5'd0, 12'd5));
        fetch(mk_i(5'd2, 5'd1, 12'd3));
        fetch(mk_r(5'd3, 5'd1, 5'd2));
        fetch(mk_r(5'd0, 5'd3, 5'd1));
        fetch(mk_i(5'd1, 5'd1, 12'h7ff));
        fetch(mk_r(5'd4, 5'd1, 5'd3));
        fetch(mk_i(5'd0, 5'd0, 12'd0));
        fetch(mk_r(5'd5, 5'd4, 5'd4));
        wait_disp(8, T_RENAME);
    endtask

    task automatic test_commit();
        run_until(disp_cnt, 8, T_COMMIT);
        checks++;
        if (retire_q.size() != 0) begin
            fail_msg("instructions left uncommitted");
        end
    endtask

    task automatic test_backpressure();
        int base_d;
        int base_c;
        int n;
        base_d = disp_cnt;
        base_c = commit_cnt;
        i_int_stall = 1'b1;
        fork
            begin
                for (int i = 0; i < 14; i++) begin
                    fetch(mk_r(5'(i % 7 + 1), 5'(i % 5), 5'(i % 3 + 2)));
                end
            end
            begin
                n = 0;
                while (!o_stall && n < 40) begin
                    tick();
                    n++;
                end
                if (!o_stall) begin
                    fail_msg("o_stall never rose under back-pressure");
                end
                tick();
                i_int_stall = 1'b0;
            end
        join
        run_until(base_d + 14, base_c + 14, T_BP);
    endtask

    task automatic test_illegal();
        int base_d;
        int base_c;
        int base_s;
        int n;
        base_d = disp_cnt;
        base_c = commit_cnt;
        base_s = squash_cnt;
        fetch(mk_i(5'd6, 5'd1, 12'd9));
        fetch(mk_r(5'd7, 5'd6, 5'd2));
        fetch(mk_i(5'd6, 5'd7, 12'd1));
        fetch(32'h0000_0063);
        fetch(mk_r(5'd8, 5'd6, 5'd7));
        fetch(mk_i(5'd6, 5'd8, 12'd2));
        fetch(mk_r(5'd9, 5'd6, 5'd6));
        wait_disp(base_d + 6, 60);
        // younger ones complete first and still must not commit
        while (pending.size() > 3) begin
            writeback(pending.size() - 1);
        end
        run_until(base_d + 6, base_c + 3, 60);
        n = 0;
        while (squash_cnt == base_s && n < 20) begin
            tick();
            n++;
        end
        repeat (10) tick();
        checks++;
        if (squash_cnt != base_s + 1 || commit_cnt != base_c + 3) begin
            fail_msg("expected one squash and no younger commits");
        end
        fetch(mk_r(5'd10, 5'd6, 5'd8));
        fetch(mk_i(5'd8, 5'd10, 12'd4));
        fetch(mk_r(5'd6, 5'd8, 5'd9));
        fetch(mk_i(5'd0, 5'd6, 12'd1));
        run_until(base_d + 10, base_c + 7, 100);
    endtask

    task automatic test_rob_full();
        int base_d;
        int base_c;
        base_d = disp_cnt;
        base_c = commit_cnt;
        fork
            begin
                for (int i = 0; i < 20; i++) begin
                    fetch(mk_i(5'(i % 9 + 11), 5'(i % 4), 12'(i)));
                end
            end
            begin
                wait_disp(base_d + ROB_DEPTH, 100);
                repeat (10) tick();
                checks++;
                if (disp_cnt != base_d + ROB_DEPTH) begin
                    errors++;
                    $display("FAIL %0t disp_cnt exp=%0d got=%0d", $time,
                             base_d + ROB_DEPTH, disp_cnt);
                end
                writeback(0);
                wait_disp(base_d + ROB_DEPTH + 1, 20);
            end
        join
        run_until(base_d + 20, base_c + 20, T_FULL);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns", TIMEOUT_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        i_rst = 1'b1;
        i_fetch_vld = 1'b0;
        i_fetch = '0;
        i_int_stall = 1'b0;
        i_wb_vld = 1'b0;
        i_wb = '0;
        held_vld = 1'b0;
        held_info = '0;
        next_rob = '0;
        fl_head = 0;
        fl_tail = 32;
        fl_comm = 0;
        for (int i = 0; i < 32; i++) begin
            spec_rat[i] = ctrl_pkg::preg_idx_t'(i);
            comm_rat[i] = ctrl_pkg::preg_idx_t'(i);
            free_q[i] = ctrl_pkg::preg_idx_t'(32 + i);
        end
        repeat (10) @(posedge clk);
        #5;
        i_rst = 1'b0;
        test_reset();
        test_rename();
        test_commit();
        test_backpressure();
        test_illegal();
        test_rob_full();
        repeat (5) tick();
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
